/* include/periph_macros.svh */
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

////////////////////////////////////////////////////////////
// apb bus geometry
////////////////////////////////////////////////////////////
`define APB_ADDR_W        32
`define APB_DATA_W        32

// slave select field, 0 soc ctrl, 1 timer, rest unmapped
`define SLV_SEL_LSB       8
`define SLV_SEL_MSB       11
`define NUM_SLAVES        2
`define REG_OFS_LSB       2     // word offset inside a slave
`define REG_OFS_MSB       7

////////////////////////////////////////////////////////////
// register byte offsets
////////////////////////////////////////////////////////////
`define SOC_BOOTADDR_OFS  8'h00
`define SOC_FETCHEN_OFS   8'h04
`define SOC_STATUS_OFS    8'h08 // bit 0 sticky bus timeout
`define SOC_SOFTRST_OFS   8'h0C
`define TMR_CFG_OFS       8'h00
`define TMR_COUNT_OFS     8'h04
`define TMR_CMP_OFS       8'h08

`define BOOT_ADDR_RST     32'h1c008080
`define RTO_CYCLES        16    // access cycles before error
`define RDATA_UNMAPPED    32'hdead_beef

// fc event vector positions
`define FC_EVT_TIMER_LO   16
`define FC_EVT_REF_RISE   18
`define FC_EVT_REF_FALL   19
`define FC_EVT_BUS_ERR    31

`endif

/* design/periph_pkg.sv */
`include "periph_macros.svh"

package periph_pkg;

  ////////////////////////////////////////////////////////////
  // bus payload types
  ////////////////////////////////////////////////////////////
  typedef logic [`APB_ADDR_W-1:0] apb_addr_t;  // byte address
  typedef logic [`APB_DATA_W-1:0] apb_data_t;  // one data word

  // word offset within one slave window
  typedef logic [`REG_OFS_MSB-`REG_OFS_LSB:0] reg_ofs_t;

  ////////////////////////////////////////////////////////////
  // decoder and fsm encodings
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    SEL_SOC_CTRL = 2'd0,  // matches slave field value 0
    SEL_TIMER    = 2'd1,  // matches slave field value 1
    SEL_NONE     = 2'd2   // unmapped, goes to timeout
  } slave_sel_e;

  typedef enum logic [1:0] {
    BUS_IDLE    = 2'd0,
    BUS_ACCESS  = 2'd1,  // setup done, waiting on penable
    BUS_TIMEOUT = 2'd2   // error response cycle
  } bus_state_e;

  ////////////////////////////////////////////////////////////
  // fabric controller events
  ////////////////////////////////////////////////////////////
  typedef logic [31:0] fc_events_t;  // one bit per event line

endpackage

/* design/periph_bus_fsm.sv */
`include "periph_macros.svh"

module periph_bus_fsm
  import periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // apb slave port
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  input  logic      pwrite_i,
  input  logic      psel_i,
  input  logic      penable_i,
  output apb_data_t prdata_o,
  output logic      pready_o,
  output logic      pslverr_o,
  // shared register port to the slaves
  output logic      soc_req_o,
  output logic      tmr_req_o,
  output logic      we_o,
  output reg_ofs_t  ofs_o,
  output apb_data_t wdata_o,
  input  apb_data_t soc_rdata_i,
  input  apb_data_t tmr_rdata_i,
  output logic      rto_o
);

  localparam int CNT_W = $clog2(`RTO_CYCLES + 1);

  bus_state_e state_q, state_d;
  slave_sel_e sel;
  logic [`SLV_SEL_MSB-`SLV_SEL_LSB:0] slv_idx;
  logic [CNT_W-1:0] rto_cnt_q;
  logic access;    // valid access cycle
  logic map_done;  // mapped slave answers now

  ////////////////////////////////////////////////////////////
  // slave decode
  ////////////////////////////////////////////////////////////
  assign slv_idx = paddr_i[`SLV_SEL_MSB:`SLV_SEL_LSB];
  assign sel     = (int'(slv_idx) < `NUM_SLAVES) ? slave_sel_e'(slv_idx[1:0]) : SEL_NONE;

  assign access   = (state_q == BUS_ACCESS) & psel_i & penable_i;
  assign map_done = access & (sel != SEL_NONE);

  ////////////////////////////////////////////////////////////
  // transfer fsm
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      BUS_IDLE: if (psel_i && !penable_i) state_d = BUS_ACCESS;  // setup phase
      BUS_ACCESS: begin
        if (!psel_i) state_d = BUS_IDLE;  // master gave up
        else if (map_done) state_d = BUS_IDLE;  // zero wait states
        else if (access && rto_cnt_q == CNT_W'(`RTO_CYCLES - 1)) state_d = BUS_TIMEOUT;
      end
      BUS_TIMEOUT: state_d = BUS_IDLE;  // error answered this cycle
      default: state_d = BUS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= BUS_IDLE;
      rto_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      // count unmapped access cycles only
      if (access && sel == SEL_NONE) rto_cnt_q <= rto_cnt_q + 1'b1;
      else rto_cnt_q <= '0;
    end
  end

  // handshake back to the master
  assign pready_o  = map_done | (state_q == BUS_TIMEOUT);
  assign pslverr_o = (state_q == BUS_TIMEOUT);
  assign rto_o     = (state_q == BUS_TIMEOUT);  // one cycle, fsm leaves at once

  // request strobes, one per slave
  assign soc_req_o = map_done & (sel == SEL_SOC_CTRL);
  assign tmr_req_o = map_done & (sel == SEL_TIMER);
  assign we_o      = pwrite_i;
  assign ofs_o     = paddr_i[`REG_OFS_MSB:`REG_OFS_LSB];
  assign wdata_o   = pwdata_i;

  // read data mux
  always_comb begin
    if (state_q == BUS_TIMEOUT) prdata_o = `RDATA_UNMAPPED;
    else if (sel == SEL_TIMER) prdata_o = tmr_rdata_i;
    else if (sel == SEL_SOC_CTRL) prdata_o = soc_rdata_i;
    else prdata_o = '0;
  end

endmodule

/* design/soc_ctrl_regs.sv */
`include "periph_macros.svh"

module soc_ctrl_regs
  import periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // register port from the bus fsm
  input  logic      req_i,
  input  logic      we_i,
  input  reg_ofs_t  ofs_i,
  input  apb_data_t wdata_i,
  input  logic      rto_i,      // bus timeout strobe
  output apb_data_t rdata_o,
  // soc control outputs
  output apb_addr_t boot_addr_o,
  output logic      fetch_en_o,
  output logic      soft_rst_o
);

  // byte offsets turned into word offsets
  localparam reg_ofs_t OFS_BOOTADDR = reg_ofs_t'(`SOC_BOOTADDR_OFS >> 2);
  localparam reg_ofs_t OFS_FETCHEN  = reg_ofs_t'(`SOC_FETCHEN_OFS >> 2);
  localparam reg_ofs_t OFS_STATUS   = reg_ofs_t'(`SOC_STATUS_OFS >> 2);
  localparam reg_ofs_t OFS_SOFTRST  = reg_ofs_t'(`SOC_SOFTRST_OFS >> 2);

  logic wr_en;
  logic rto_flag_q;  // sticky timeout status

  assign wr_en = req_i & we_i;

  ////////////////////////////////////////////////////////////
  // boot and fetch control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      boot_addr_o <= `BOOT_ADDR_RST;
      fetch_en_o  <= 1'b0;  // core held until sw enables fetch
    end else if (wr_en) begin
      if (ofs_i == OFS_BOOTADDR) boot_addr_o <= wdata_i;
      if (ofs_i == OFS_FETCHEN) fetch_en_o <= wdata_i[0];
    end
  end

  ////////////////////////////////////////////////////////////
  // status and soft reset
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rto_flag_q <= 1'b0;
    end else if (rto_i) begin
      rto_flag_q <= 1'b1;  // set wins over clear
    end else if (wr_en && ofs_i == OFS_STATUS && wdata_i[0]) begin
      rto_flag_q <= 1'b0;  // write one to clear
    end
  end

  // single cycle pulse, peripherals reset on the next edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) soft_rst_o <= 1'b0;
    else soft_rst_o <= wr_en & (ofs_i == OFS_SOFTRST) & wdata_i[0];
  end

  // readback
  always_comb begin
    case (ofs_i)
      OFS_BOOTADDR: rdata_o = boot_addr_o;
      OFS_FETCHEN:  rdata_o = {31'b0, fetch_en_o};
      OFS_STATUS:   rdata_o = {31'b0, rto_flag_q};
      default:      rdata_o = '0;  // soft reset reads as zero
    endcase
  end

endmodule

/* design/timer_unit.sv */
`include "periph_macros.svh"

module timer_unit
  import periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // register port from the bus fsm
  input  logic      req_i,
  input  logic      we_i,
  input  reg_ofs_t  ofs_i,
  input  apb_data_t wdata_i,
  // tick sources
  input  logic      ref_rise_i,   // synced slow clock rise
  input  logic      stoptimer_i,  // debug halt freezes count
  output apb_data_t rdata_o,
  output logic      lo_evt_o
);

  localparam reg_ofs_t OFS_CFG   = reg_ofs_t'(`TMR_CFG_OFS >> 2);
  localparam reg_ofs_t OFS_COUNT = reg_ofs_t'(`TMR_COUNT_OFS >> 2);
  localparam reg_ofs_t OFS_CMP   = reg_ofs_t'(`TMR_CMP_OFS >> 2);

  // config bit positions
  localparam int CFG_EN  = 0;
  localparam int CFG_SRC = 1;  // 1 counts ref_rise_i
  localparam int CFG_CLR = 2;  // clear on match

  logic [2:0] cfg_q;
  apb_data_t  cnt_q;
  apb_data_t  cmp_q;
  apb_data_t  cnt_inc;
  logic       wr_en;
  logic       tick;
  logic       match;

  assign wr_en   = req_i & we_i;
  assign tick    = cfg_q[CFG_EN] & ~stoptimer_i & (cfg_q[CFG_SRC] ? ref_rise_i : 1'b1);
  assign cnt_inc = cnt_q + 32'd1;
  assign match   = tick & (cnt_inc == cmp_q);

  ////////////////////////////////////////////////////////////
  // config and compare
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
      cmp_q <= '0;
    end else if (wr_en) begin
      if (ofs_i == OFS_CFG) cfg_q <= wdata_i[2:0];
      if (ofs_i == OFS_CMP) cmp_q <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) cnt_q <= '0;
    else if (wr_en && ofs_i == OFS_COUNT) cnt_q <= wdata_i;  // sw load wins
    else if (tick) cnt_q <= (match && cfg_q[CFG_CLR]) ? '0 : cnt_inc;
  end

  assign lo_evt_o = match;  // router registers it

  always_comb begin
    case (ofs_i)
      OFS_CFG:   rdata_o = {29'b0, cfg_q};
      OFS_COUNT: rdata_o = cnt_q;
      OFS_CMP:   rdata_o = cmp_q;
      default:   rdata_o = '0;
    endcase
  end

endmodule

/* design/fc_event_router.sv */
`include "periph_macros.svh"

module fc_event_router
  import periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       slow_clk_i,    // async reference clock
  input  logic       tmr_lo_evt_i,
  input  logic       rto_i,         // bus timeout strobe
  output logic       ref_rise_o,    // to the timer tick select
  output fc_events_t fc_events_o
);

  logic sync1_q, sync2_q;  // two flop synchronizer
  logic prev_q;            // last synced level
  logic rise, fall;

  ////////////////////////////////////////////////////////////
  // slow clock sync and edge detect
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      prev_q  <= 1'b0;
    end else begin
      sync1_q <= slow_clk_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise       = sync2_q & ~prev_q;
  assign fall       = ~sync2_q & prev_q;
  assign ref_rise_o = rise;

  // event vector, unused bits held at zero
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fc_events_o <= '0;
    end else begin
      fc_events_o                   <= '0;
      fc_events_o[`FC_EVT_TIMER_LO] <= tmr_lo_evt_i;
      fc_events_o[`FC_EVT_REF_RISE] <= rise;
      fc_events_o[`FC_EVT_REF_FALL] <= fall;
      fc_events_o[`FC_EVT_BUS_ERR]  <= rto_i;
    end
  end

endmodule

/* design/soc_periph_top.sv */
module soc_periph_top
  import periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       slow_clk_i,
  input  logic       stoptimer_i,
  // apb slave port
  input  apb_addr_t  paddr_i,
  input  apb_data_t  pwdata_i,
  input  logic       pwrite_i,
  input  logic       psel_i,
  input  logic       penable_i,
  output apb_data_t  prdata_o,
  output logic       pready_o,
  output logic       pslverr_o,
  // to the fabric controller
  output apb_addr_t  boot_addr_o,
  output logic       fetch_en_o,
  output fc_events_t fc_events_o
);

  logic      soc_req, tmr_req, we;
  reg_ofs_t  ofs;
  apb_data_t wdata, soc_rdata, tmr_rdata;
  logic      rto_pulse;
  logic      soft_rst;
  logic      periph_rst_n;  // por or soft reset
  logic      ref_rise, tmr_lo_evt;

  // soft reset spares the bus and the control bank
  assign periph_rst_n = rst_n_i & ~soft_rst;

  ////////////////////////////////////////////////////////////
  // bus decoder and slaves
  ////////////////////////////////////////////////////////////
  periph_bus_fsm u_bus_fsm (
    .clk_i, .rst_n_i, .paddr_i, .pwdata_i, .pwrite_i, .psel_i, .penable_i,
    .prdata_o, .pready_o, .pslverr_o,
    .soc_req_o(soc_req), .tmr_req_o(tmr_req), .we_o(we), .ofs_o(ofs), .wdata_o(wdata),
    .soc_rdata_i(soc_rdata), .tmr_rdata_i(tmr_rdata), .rto_o(rto_pulse)
  );

  soc_ctrl_regs u_soc_ctrl (
    .clk_i, .rst_n_i, .req_i(soc_req), .we_i(we), .ofs_i(ofs), .wdata_i(wdata),
    .rto_i(rto_pulse), .rdata_o(soc_rdata), .boot_addr_o, .fetch_en_o, .soft_rst_o(soft_rst)
  );

  timer_unit u_timer (
    .clk_i, .rst_n_i(periph_rst_n), .req_i(tmr_req), .we_i(we), .ofs_i(ofs), .wdata_i(wdata),
    .ref_rise_i(ref_rise), .stoptimer_i, .rdata_o(tmr_rdata), .lo_evt_o(tmr_lo_evt)
  );

  fc_event_router u_evt_router (
    .clk_i, .rst_n_i(periph_rst_n), .slow_clk_i, .tmr_lo_evt_i(tmr_lo_evt),
    .rto_i(rto_pulse), .ref_rise_o(ref_rise), .fc_events_o
  );

endmodule

/* tb/tb_soc_periph.sv */
`include "periph_macros.svh"

module tb_soc_periph
  import periph_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int XFER_TIMEOUT = 64;    // access cycles per transfer
  localparam int EVT_TIMEOUT  = 4096;  // cycles to wait for an event

  logic       clk, rst_n, slow_clk, stoptimer;
  apb_addr_t  paddr;
  apb_data_t  pwdata, prdata;
  logic       pwrite, psel, penable, pready, pslverr;
  apb_addr_t  boot_addr;
  logic       fetch_en;
  fc_events_t fc_events;

  int          mismatch_cnt = 0;
  int          timeout_cnt  = 0;
  logic [31:0] rand_state   = 32'h15a99a3d;

  // reference model of the register state
  apb_data_t  m_boot, m_cmp;
  logic       m_fetch, m_rto;
  logic [2:0] m_cfg;

  soc_periph_top u_soc_periph_top (
    .clk_i(clk), .rst_n_i(rst_n), .slow_clk_i(slow_clk), .stoptimer_i(stoptimer),
    .paddr_i(paddr), .pwdata_i(pwdata), .pwrite_i(pwrite), .psel_i(psel),
    .penable_i(penable), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .boot_addr_o(boot_addr), .fetch_en_o(fetch_en), .fc_events_o(fc_events)
  );

  ////////////////////////////////////////////////////////////
  // random numbers and addresses
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return {rand_state[15:0], rand_state[31:16]};  // high bits are the better ones
  endfunction

  function automatic int rand_range(input int lo, input int span);
    return lo + int'(next_rand() % 32'(span));
  endfunction

  // upper address bits are don't care for the decoder
  function automatic apb_addr_t make_addr(input logic [3:0] slv, input logic [7:0] ofs);
    logic [31:0] r;
    r = next_rand();
    return {r[31:12], slv, ofs};
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%08h exp 0x%08h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input apb_addr_t got, input apb_addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%08h exp 0x%08h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_events(input string name, input fc_events_t got, input fc_events_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%08h exp 0x%08h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%0h exp 0x%0h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // apb driver
  ////////////////////////////////////////////////////////////
  task automatic advance_cycle();
    @(posedge clk);
    #1;  // drive slot after the edge
  endtask

  task automatic apb_transfer(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err, output int cycles);
    bit done;
    done   = 1'b0;
    cycles = 0;
    rdata  = '0;
    err    = 1'b0;
    advance_cycle();
    paddr   = addr;  // setup phase
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    advance_cycle();
    penable = 1'b1;
    while (!done && cycles < XFER_TIMEOUT) begin
      @(negedge clk);  // comb handshake settled here
      cycles++;
      if (pready) begin
        rdata = prdata;
        err   = pslverr;
        done  = 1'b1;
      end
      advance_cycle();
    end
    psel    = 1'b0;
    penable = 1'b0;
    if (!done) begin
      $display("timeout: no pready from the DUT after %0d access cycles", cycles);
      timeout_cnt++;
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
    apb_data_t rd;
    logic      err;
    int        cycles;
    apb_transfer(addr, 1'b1, wdata, rd, err, cycles);
    check_data("write access cycles", apb_data_t'(cycles), 32'd1);  // zero wait states
    check_bit("write pslverr_o", err, 1'b0);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
    logic err;
    int   cycles;
    apb_transfer(addr, 1'b0, '0, rdata, err, cycles);
    check_data("read access cycles", apb_data_t'(cycles), 32'd1);
    check_bit("read pslverr_o", err, 1'b0);
  endtask

  // toggle the slow clock and watch its event bit pulse 3 cycles later
  task automatic drive_ref_edge(input int bit_pos);
    int         gap;
    fc_events_t expected;
    gap = rand_range(8, 8);
    advance_cycle();
    slow_clk = ~slow_clk;
    // k counts the toggle cycle as 1, so cycle 3 after it is k 4
    for (int k = 1; k <= 5; k++) begin
      @(negedge clk);
      expected = '0;
      if (k == 4) expected[bit_pos] = 1'b1;
      check_events("fc_events_o ref edge", fc_events, expected);
    end
    repeat (gap - 5) advance_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #500000;
    $display("watchdog: simulation did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    apb_data_t rd, rd2, wd;
    logic      err;
    int        cycles, wait_cnt, gap, n_rise;
    rst_n     = 1'b0;
    slow_clk  = 1'b0;
    stoptimer = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pwrite    = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    repeat (16) advance_cycle();
    rst_n = 1'b1;

    // reset values
    @(negedge clk);
    check_addr("boot_addr_o", boot_addr, `BOOT_ADDR_RST);
    check_bit("fetch_en_o", fetch_en, 1'b0);
    check_bit("pready_o", pready, 1'b0);
    check_bit("pslverr_o", pslverr, 1'b0);
    check_events("fc_events_o", fc_events, '0);
    m_boot  = `BOOT_ADDR_RST;
    m_fetch = 1'b0;
    m_rto   = 1'b0;

    // random boot address and fetch enable traffic
    for (int i = 0; i < 8; i++) begin
      wd = next_rand();
      apb_write(make_addr(4'd0, `SOC_BOOTADDR_OFS), wd);
      m_boot = wd;
      wd = next_rand();
      apb_write(make_addr(4'd0, `SOC_FETCHEN_OFS), wd);
      m_fetch = wd[0];  // only bit 0 is stored
      apb_read(make_addr(4'd0, `SOC_BOOTADDR_OFS), rd);
      check_data("boot_addr readback", rd, m_boot);
      apb_read(make_addr(4'd0, `SOC_FETCHEN_OFS), rd);
      check_data("fetch_en readback", rd, {31'b0, m_fetch});
      check_addr("boot_addr_o", boot_addr, m_boot);
      check_bit("fetch_en_o", fetch_en, m_fetch);
    end

    ////////////////////////////////////////////////////////////
    // unmapped access and bus error
    ////////////////////////////////////////////////////////////
    apb_transfer(make_addr(4'(rand_range(2, 14)), 8'(rand_range(0, 64) * 4)), 1'b0, '0,
                 rd, err, cycles);
    check_data("unmapped prdata_o", rd, `RDATA_UNMAPPED);
    check_bit("unmapped pslverr_o", err, 1'b1);
    check_data("unmapped access cycles", apb_data_t'(cycles), apb_data_t'(`RTO_CYCLES + 1));
    m_rto = 1'b1;
    @(negedge clk);  // one cycle after the timeout cycle
    check_events("fc_events_o bus error", fc_events, fc_events_t'(1) << `FC_EVT_BUS_ERR);
    @(negedge clk);
    check_events("fc_events_o after bus error", fc_events, '0);
    apb_read(make_addr(4'd0, `SOC_STATUS_OFS), rd);
    check_data("status readback", rd, {31'b0, m_rto});
    apb_write(make_addr(4'd0, `SOC_STATUS_OFS), 32'h1);  // write one to clear
    m_rto = 1'b0;
    apb_read(make_addr(4'd0, `SOC_STATUS_OFS), rd);
    check_data("status after clear", rd, {31'b0, m_rto});

    ////////////////////////////////////////////////////////////
    // timer on the system clock
    ////////////////////////////////////////////////////////////
    m_cmp = apb_data_t'(rand_range(32, 224));
    m_cfg = 3'b101;  // enable, clear on match
    apb_write(make_addr(4'd1, `TMR_CMP_OFS), m_cmp);
    apb_write(make_addr(4'd1, `TMR_COUNT_OFS), '0);
    apb_write(make_addr(4'd1, `TMR_CFG_OFS), {29'b0, m_cfg});
    wait_cnt = 0;
    while (!fc_events[`FC_EVT_TIMER_LO] && wait_cnt < EVT_TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!fc_events[`FC_EVT_TIMER_LO]) begin
      $display("timeout: timer low event never showed on fc_events_o");
      timeout_cnt++;
    end
    apb_read(make_addr(4'd1, `TMR_COUNT_OFS), rd);
    check_bit("tmr count below compare", rd < m_cmp, 1'b1);
    apb_read(make_addr(4'd1, `TMR_CFG_OFS), rd);
    check_data("tmr cfg readback", rd, {29'b0, m_cfg});
    apb_read(make_addr(4'd1, `TMR_CMP_OFS), rd);
    check_data("tmr cmp readback", rd, m_cmp);

    // stoptimer freezes the count
    advance_cycle();
    stoptimer = 1'b1;
    apb_read(make_addr(4'd1, `TMR_COUNT_OFS), rd);
    gap = rand_range(4, 32);
    repeat (gap) advance_cycle();
    apb_read(make_addr(4'd1, `TMR_COUNT_OFS), rd2);
    check_data("tmr count while stopped", rd2, rd);
    stoptimer = 1'b0;
    m_cfg = 3'b000;
    apb_write(make_addr(4'd1, `TMR_CFG_OFS), {29'b0, m_cfg});

    ////////////////////////////////////////////////////////////
    // reference clock edges and timer on ref rise
    ////////////////////////////////////////////////////////////
    m_cmp = 32'hffff_ffff;  // out of reach so no low event fires
    m_cfg = 3'b011;
    apb_write(make_addr(4'd1, `TMR_CMP_OFS), m_cmp);
    apb_write(make_addr(4'd1, `TMR_COUNT_OFS), '0);
    apb_write(make_addr(4'd1, `TMR_CFG_OFS), {29'b0, m_cfg});
    n_rise = rand_range(3, 4);
    for (int i = 0; i < n_rise; i++) begin
      drive_ref_edge(`FC_EVT_REF_RISE);
      drive_ref_edge(`FC_EVT_REF_FALL);
    end
    apb_read(make_addr(4'd1, `TMR_COUNT_OFS), rd);
    check_data("tmr ref rise count", rd, apb_data_t'(n_rise));

    // soft reset hits the timer only
    apb_write(make_addr(4'd0, `SOC_SOFTRST_OFS), 32'h1);
    m_cfg = 3'b000;
    m_cmp = '0;
    apb_read(make_addr(4'd1, `TMR_CFG_OFS), rd);
    check_data("tmr cfg after soft reset", rd, {29'b0, m_cfg});
    apb_read(make_addr(4'd1, `TMR_COUNT_OFS), rd);
    check_data("tmr count after soft reset", rd, '0);
    apb_read(make_addr(4'd1, `TMR_CMP_OFS), rd);
    check_data("tmr cmp after soft reset", rd, m_cmp);
    apb_read(make_addr(4'd0, `SOC_SOFTRST_OFS), rd);
    check_data("softrst readback", rd, '0);
    apb_read(make_addr(4'd0, `SOC_BOOTADDR_OFS), rd);
    check_data("boot_addr after soft reset", rd, m_boot);
    apb_read(make_addr(4'd0, `SOC_FETCHEN_OFS), rd);
    check_data("fetch_en after soft reset", rd, {31'b0, m_fetch});
    check_addr("boot_addr_o", boot_addr, m_boot);
    check_bit("fetch_en_o", fetch_en, m_fetch);

    $display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+include
design/periph_pkg.sv
design/periph_bus_fsm.sv
design/soc_ctrl_regs.sv
design/timer_unit.sv
design/fc_event_router.sv
design/soc_periph_top.sv
tb/tb_soc_periph.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, scan the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_soc_periph -f files.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0
